/* bench/decodeChecker.sv */
`timescale 1ns/100ps

module decodeChecker import mipsIsaPkg::*, decodeCtrlPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        expStrobe,
    input  int          expNum,
    input  aluOpT       expAluOp,
    input  logic [13:0] expFlags,
    input  branchT      expBranch,
    input  logic        expLink,
    input  regAddrT     expWaddr,
    input  logic [31:0] expImm,
    input  logic        decodedValid,
    input  aluOpT       aluOp,
    input  logic [13:0] flags,      // aluSelA in bit 13 down to undefinedInst in bit 0
    input  branchT      branchType,
    input  logic        linkPc8,
    input  regAddrT     regWaddr,
    input  logic [31:0] extImm,
    output int          errorCount,
    output int          testCount
);

    logic        pendValid = 1'b0;
    int          pendNum;
    aluOpT       pendAluOp;
    logic [13:0] pendFlags;
    branchT      pendBranch;
    logic        pendLink;
    regAddrT     pendWaddr;
    logic [31:0] pendImm;
    int          failCount = 0;
    int          idleErrors = 0;
    int          testsSeen = 0;

    assign errorCount = failCount + idleErrors;
    assign testCount  = testsSeen;

    function automatic string flagName(int b);
        case (b)
            13: return "aluSelA";
            12: return "aluSelB";
            11: return "regWen";
            10: return "memEn";
            9:  return "memRead";
            8:  return "memWrite";
            7:  return "memToReg";
            6:  return "hiloWrite";
            5:  return "cp0Write";
            4:  return "privInst";
            3:  return "excSyscall";
            2:  return "excBreak";
            1:  return "excEret";
            default: return "undefinedInst";
        endcase
    endfunction

    task automatic compare(input string tag, input string name, input logic [31:0] act,
                           input logic [31:0] exp, inout int bad);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s %s expected %0h actual %0h",
                     $time, tag, name, exp, act);
            bad++;
        end
    endtask

    task automatic compareFlags(input string tag, input logic [13:0] exp, inout int bad);
        for (int b = 13; b >= 0; b--) begin
            compare(tag, flagName(b), flags[b], exp[b], bad);
        end
    endtask

    // the strobe cycle's expectations, due one cycle later
    always @(posedge clk) begin
        pendValid  <= expStrobe;
        pendNum    <= expNum;
        pendAluOp  <= expAluOp;
        pendFlags  <= expFlags;
        pendBranch <= expBranch;
        pendLink   <= expLink;
        pendWaddr  <= expWaddr;
        pendImm    <= expImm;
    end

    always @(negedge clk) begin
        int    bad;
        string tag;
        bad = 0;
        if (pendValid) begin
            tag = $sformatf("test %0d", pendNum);
            compare(tag, "decodedValid", decodedValid, 1'b1, bad);
            compare(tag, "aluOp", aluOp, pendAluOp, bad);
            compareFlags(tag, pendFlags, bad);
            compare(tag, "branchType", branchType, pendBranch, bad);
            compare(tag, "linkPc8", linkPc8, pendLink, bad);
            compare(tag, "regWaddr", regWaddr, pendWaddr, bad);
            compare(tag, "extImm", extImm, pendImm, bad);
            testsSeen++;
            if (bad != 0) begin
                failCount++;
            end
            $display("test %0d %s, %0d mismatches", pendNum, (bad == 0) ? "ok" : "failed", bad);
        end else begin
            tag = rstN ? "idle cycle" : "reset";  // nothing may be enabled here
            compare(tag, "decodedValid", decodedValid, 1'b0, bad);
            compare(tag, "aluOp", aluOp, aluNop, bad);
            compareFlags(tag, 14'h0000, bad);
            compare(tag, "branchType", branchType, btNop, bad);
            compare(tag, "linkPc8", linkPc8, 1'b0, bad);
            idleErrors += bad;
        end
    end

    task printCounts();
        $display("tests %0d, passed %0d, failed %0d, idle-cycle mismatches %0d",
                 testsSeen, testsSeen - failCount, failCount, idleErrors);
    endtask

endmodule

/* bench/decodeStageTb.sv */
`timescale 1ns/100ps

module decodeStageTb import mipsIsaPkg::*, decodeCtrlPkg::*; ();

    localparam int clkPeriod = 40;
    localparam int dstRd = 0;
    localparam int dstRt = 1;
    localparam int dstRa = 2;

    // same bit order as the checker's flags port
    localparam logic [13:0] fSelA     = 14'h2000;
    localparam logic [13:0] fSelB     = 14'h1000;
    localparam logic [13:0] fRegWen   = 14'h0800;
    localparam logic [13:0] fMemEn    = 14'h0400;
    localparam logic [13:0] fMemRd    = 14'h0200;
    localparam logic [13:0] fMemWr    = 14'h0100;
    localparam logic [13:0] fMemToReg = 14'h0080;
    localparam logic [13:0] fHilo     = 14'h0040;
    localparam logic [13:0] fCp0      = 14'h0020;
    localparam logic [13:0] fPriv     = 14'h0010;
    localparam logic [13:0] fSys      = 14'h0008;
    localparam logic [13:0] fBrk      = 14'h0004;
    localparam logic [13:0] fEret     = 14'h0002;
    localparam logic [13:0] fUndef    = 14'h0001;
    localparam logic [13:0] fLoad     = fSelB | fRegWen | fMemEn | fMemRd | fMemToReg;
    localparam logic [13:0] fStore    = fSelB | fMemEn | fMemWr;
    localparam logic [13:0] fImm      = fSelB | fRegWen;

    logic        clk = 1'b0;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic        decodedValid;
    aluOpT       aluOp;
    logic        aluSelA;
    logic        aluSelB;
    logic        regWen;
    logic        memEn;
    logic        memRead;
    logic        memWrite;
    logic        memToReg;
    logic        hiloWrite;
    logic        cp0Write;
    logic        privInst;
    logic        excSyscall;
    logic        excBreak;
    logic        excEret;
    logic        undefinedInst;
    branchT      branchType;
    logic        linkPc8;
    regAddrT     regWaddr;
    logic [31:0] extImm;

    logic [31:0] tInstr[$];
    aluOpT       tAluOp[$];
    logic [13:0] tFlags[$];
    branchT      tBranch[$];
    logic        tLink[$];
    regAddrT     tWaddr[$];
    logic        tGap[$];

    logic        expStrobe;
    int          expNum;
    aluOpT       expAluOp;
    logic [13:0] expFlags;
    branchT      expBranch;
    logic        expLink;
    regAddrT     expWaddr;
    logic [31:0] expImm;
    logic        tableReady;
    int          chkErrors;
    int          chkTests;

    function automatic logic [4:0] randReg();
        logic [31:0] r;
        r = $urandom();
        return r[4:0];
    endfunction

    function automatic logic [31:0] specialWord(logic [5:0] funct);
        return {opSpecial, randReg(), randReg(), randReg(), randReg(), funct};
    endfunction

    function automatic logic [31:0] immWord(logic [5:0] op, logic [15:0] imm);
        return {op, randReg(), randReg(), imm};
    endfunction

    function automatic logic [31:0] regimmWord(logic [4:0] rtCode, logic [15:0] imm);
        return {opRegimm, randReg(), rtCode, imm};
    endfunction

    function automatic logic [31:0] cop0Word(logic [4:0] rsCode);
        return {opCop0, rsCode, randReg(), randReg(), 11'h000};
    endfunction

    function automatic logic [31:0] jumpWord(logic [5:0] op);
        logic [31:0] r;
        r = $urandom();
        return {op, r[25:0]};
    endfunction

    // logic-immediate group zero-extends, all else sign-extends
    function automatic logic [31:0] extendImm(logic [31:0] word);
        if (word[29] && word[28]) begin
            return {16'h0000, word[15:0]};
        end
        return {{16{word[15]}}, word[15:0]};
    endfunction

    task automatic addEntry(input logic [31:0] word, input aluOpT op, input logic [13:0] fl,
                            input branchT bt, input logic link, input int dst);
        regAddrT dest;
        case (dst)
            dstRt:   dest = word[rtLsb +: rtW];
            dstRa:   dest = 5'd31;
            default: dest = word[rdLsb +: rdW];
        endcase
        tInstr.push_back(word);
        tAluOp.push_back(op);
        tFlags.push_back(fl);
        tBranch.push_back(bt);
        tLink.push_back(link);
        tWaddr.push_back(dest);
        tGap.push_back(($urandom() % 3) == 0);
    endtask

    task automatic buildTable();
        addEntry(specialWord(fnAddu), aluAddu, fRegWen, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnSub), aluSub, fRegWen, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnAnd), aluAnd, fRegWen, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnXor), aluXor, fRegWen, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnNor), aluNor, fRegWen, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnSlt), aluSlt, fRegWen, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnSll), aluSll, fSelA | fRegWen, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnSrl), aluSrl, fSelA | fRegWen, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnSra), aluSra, fSelA | fRegWen, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnSrlv), aluSrlv, fRegWen, btNop, 1'b0, dstRd);
        addEntry(immWord(opLw, 16'hfff8), aluAddu, fLoad, btNop, 1'b0, dstRt);
        addEntry(immWord(opLbu, 16'h0010), aluAddu, fLoad, btNop, 1'b0, dstRt);
        addEntry(immWord(opSw, 16'h8004), aluAddu, fStore, btNop, 1'b0, dstRd);
        addEntry(immWord(opSh, 16'h0002), aluAddu, fStore, btNop, 1'b0, dstRd);
        addEntry(immWord(opOri, 16'h8001), aluOr, fImm, btNop, 1'b0, dstRt);
        addEntry(immWord(opAndi, 16'hf0f0), aluAnd, fImm, btNop, 1'b0, dstRt);
        addEntry(immWord(opAddi, 16'h8000), aluAdd, fImm, btNop, 1'b0, dstRt);
        addEntry(immWord(opLui, 16'h1234), aluLui, fImm, btNop, 1'b0, dstRt);
        addEntry(jumpWord(opJ), aluNop, '0, btJ, 1'b0, dstRd);
        addEntry(jumpWord(opJal), aluNop, fRegWen, btJ, 1'b1, dstRa);
        addEntry(specialWord(fnJr), aluNop, '0, btJreg, 1'b0, dstRd);
        addEntry(specialWord(fnJalr), aluNop, fRegWen, btJreg, 1'b1, dstRd);
        addEntry(immWord(opBeq, 16'hfffc), aluNop, '0, btBeq, 1'b0, dstRd);
        addEntry(immWord(opBne, 16'h0020), aluNop, '0, btBne, 1'b0, dstRd);
        addEntry(immWord(opBlez, 16'h8000), aluNop, '0, btBlez, 1'b0, dstRd);
        addEntry(immWord(opBgtz, 16'h0004), aluNop, '0, btBgtz, 1'b0, dstRd);
        addEntry(regimmWord(rtBgez, 16'h0008), aluNop, '0, btBgez, 1'b0, dstRd);
        addEntry(regimmWord(rtBltzal, 16'hff00), aluNop, fRegWen, btBltz, 1'b1, dstRa);
        addEntry(specialWord(fnMult), aluMult, fHilo, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnDivu), aluDivu, fHilo, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnMthi), aluMthi, fHilo, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnMfhi), aluMfhi, fRegWen, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnMflo), aluMflo, fRegWen, btNop, 1'b0, dstRd);
        addEntry(cop0Word(rsMfc0), aluMfc0, fPriv | fRegWen, btNop, 1'b0, dstRt);
        addEntry(cop0Word(rsMtc0), aluMtc0, fPriv | fCp0, btNop, 1'b0, dstRd);
        addEntry(eretWord, aluNop, fPriv | fEret, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnSyscall), aluNop, fPriv | fSys, btNop, 1'b0, dstRd);
        addEntry(specialWord(fnBreak), aluNop, fPriv | fBrk, btNop, 1'b0, dstRd);
        addEntry(specialWord(6'b110100), aluNop, fUndef, btNop, 1'b0, dstRd); // teq
        addEntry(jumpWord(6'b011100), aluNop, fUndef, btNop, 1'b0, dstRd);    // SPECIAL2
        addEntry(regimmWord(5'b11111, 16'h0040), aluNop, '0, btNop, 1'b0, dstRd); // synci
    endtask

    decodeStage dut0 (.*);

    decodeChecker chk0 (
        .clk         (clk),
        .rstN        (rstN),
        .expStrobe   (expStrobe),
        .expNum      (expNum),
        .expAluOp    (expAluOp),
        .expFlags    (expFlags),
        .expBranch   (expBranch),
        .expLink     (expLink),
        .expWaddr    (expWaddr),
        .expImm      (expImm),
        .decodedValid(decodedValid),
        .aluOp       (aluOp),
        .flags       ({aluSelA, aluSelB, regWen, memEn, memRead, memWrite, memToReg,
                       hiloWrite, cp0Write, privInst, excSyscall, excBreak, excEret,
                       undefinedInst}),
        .branchType  (branchType),
        .linkPc8     (linkPc8),
        .regWaddr    (regWaddr),
        .extImm      (extImm),
        .errorCount  (chkErrors),
        .testCount   (chkTests)
    );

    initial begin
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        expStrobe  = 1'b0;
        expNum     = 0;
        expAluOp   = aluNop;
        expFlags   = '0;
        expBranch  = btNop;
        expLink    = 1'b0;
        expWaddr   = '0;
        expImm     = '0;
        tableReady = 1'b0;
        void'($urandom(32'h7743)); // one seed for the whole run
        buildTable();
        tableReady = 1'b1;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < tInstr.size(); i++) begin
            @(posedge clk);
            instrValid <= 1'b1;
            instr      <= tInstr[i];
            expStrobe  <= 1'b1;
            expNum     <= i;
            expAluOp   <= tAluOp[i];
            expFlags   <= tFlags[i];
            expBranch  <= tBranch[i];
            expLink    <= tLink[i];
            expWaddr   <= tWaddr[i];
            expImm     <= extendImm(tInstr[i]);
            if (tGap[i]) begin
                @(posedge clk);
                instrValid <= 1'b0;
                instr      <= $urandom(); // junk, must be ignored
                expStrobe  <= 1'b0;
            end
        end
        @(posedge clk);
        instrValid <= 1'b0;
        expStrobe  <= 1'b0;
        repeat (3) @(posedge clk);
        chk0.printCounts();
        if (chkTests != tInstr.size()) begin
            $display("checker finished %0d tests but the table holds %0d",
                     chkTests, tInstr.size());
        end
        if (chkErrors == 0 && chkTests == tInstr.size()) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // limit scales with the table
    initial begin
        wait (tableReady);
        repeat ((tInstr.size() + 10) * 2) @(posedge clk);
        $display("run timed out before all table entries were checked");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* decodeStage.f */
hw/mipsIsaPkg.sv
hw/decodeCtrlPkg.sv
hw/ctrlDecoder.sv
hw/branchDecoder.sv
hw/operandDecoder.sv
hw/decodeStage.sv
bench/decodeChecker.sv
bench/decodeStageTb.sv

/* hw/branchDecoder.sv */
`timescale 1ns/100ps

module branchDecoder import mipsIsaPkg::*, decodeCtrlPkg::*; (
    input  logic [instrW-1:0] instr,
    output branchT            branchType,
    output logic              linkPc8
);

    logic [opW-1:0]    op;
    logic [rtW-1:0]    rt;
    logic [functW-1:0] funct;

    assign op    = instr[opLsb +: opW];
    assign rt    = instr[rtLsb +: rtW];
    assign funct = instr[functLsb +: functW];

    always_comb begin
        branchType = branchRst;
        linkPc8    = flagRst;
        case (op)
            opSpecial: begin
                if (funct == fnJr || funct == fnJalr) begin
                    branchType = btJreg;
                    linkPc8    = (funct == fnJalr);
                end
            end
            opJ:    branchType = btJ;
            opJal: begin
                branchType = btJ;
                linkPc8    = 1'b1; // ra = pc+8
            end
            opBeq:  branchType = btBeq;
            opBne:  branchType = btBne;
            opBgtz: branchType = btBgtz;
            opBlez: branchType = btBlez;
            opRegimm: begin
                case (rt)
                    rtBgez, rtBgezal: branchType = btBgez;
                    rtBltz, rtBltzal: branchType = btBltz;
                    default:          branchType = branchRst; // synci and unknown rt
                endcase
                linkPc8 = (rt == rtBgezal) || (rt == rtBltzal);
            end
            default: branchType = branchRst;
        endcase
    end

endmodule

/* hw/ctrlDecoder.sv */
`timescale 1ns/100ps

module ctrlDecoder import mipsIsaPkg::*, decodeCtrlPkg::*; (
    input  logic [instrW-1:0] instr,
    output aluOpT             aluOp,
    output logic              aluSelA,
    output logic              aluSelB,
    output logic              regWen,
    output logic              memEn,
    output logic              memRead,
    output logic              memWrite,
    output logic              memToReg,
    output logic              hiloWrite,
    output logic              cp0Write,
    output logic              privInst,
    output logic              excSyscall,
    output logic              excBreak,
    output logic              excEret,
    output logic              undefinedInst
);

    logic [opW-1:0]    op;
    logic [rsW-1:0]    rs;
    logic [rtW-1:0]    rt;
    logic [functW-1:0] funct;

    assign op      = instr[opLsb +: opW];
    assign rs      = instr[rsLsb +: rsW];
    assign rt      = instr[rtLsb +: rtW];
    assign funct   = instr[functLsb +: functW];
    assign excEret = (instr == eretWord); // whole word must match

    always_comb begin
        aluOp         = aluNop;
        aluSelA       = 1'b0;
        aluSelB       = 1'b0;
        regWen        = 1'b0;
        memEn         = 1'b0;
        memRead       = 1'b0;
        memWrite      = 1'b0;
        memToReg      = 1'b0;
        hiloWrite     = 1'b0;
        cp0Write      = 1'b0;
        privInst      = 1'b0;
        excSyscall    = 1'b0;
        excBreak      = 1'b0;
        undefinedInst = 1'b0;
        case (op)
            opSpecial: begin
                regWen = 1'b1; // most functs write rd
                case (funct)
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnNor:  aluOp = aluNor;
                    fnSlt:  aluOp = aluSlt;
                    fnSltu: aluOp = aluSltu;
                    fnAdd:  aluOp = aluAdd;
                    fnAddu: aluOp = aluAddu;
                    fnSub:  aluOp = aluSub;
                    fnSubu: aluOp = aluSubu;
                    fnSllv: aluOp = aluSllv;
                    fnSrlv: aluOp = aluSrlv;
                    fnSrav: aluOp = aluSrav;
                    fnSll: begin
                        aluOp   = aluSll;
                        aluSelA = 1'b1; // shamt as operand a
                    end
                    fnSrl: begin
                        aluOp   = aluSrl;
                        aluSelA = 1'b1;
                    end
                    fnSra: begin
                        aluOp   = aluSra;
                        aluSelA = 1'b1;
                    end
                    fnMult, fnMultu, fnDiv, fnDivu, fnMthi, fnMtlo: begin
                        regWen    = 1'b0;
                        hiloWrite = 1'b1;
                        case (funct)
                            fnMult:  aluOp = aluMult;
                            fnMultu: aluOp = aluMultu;
                            fnDiv:   aluOp = aluDiv;
                            fnDivu:  aluOp = aluDivu;
                            fnMthi:  aluOp = aluMthi;
                            default: aluOp = aluMtlo;
                        endcase
                    end
                    fnMfhi: aluOp = aluMfhi;
                    fnMflo: aluOp = aluMflo;
                    fnJr:   regWen = 1'b0;
                    fnJalr: aluOp = aluNop; // pc+8 into rd
                    fnSyscall: begin
                        regWen     = 1'b0;
                        excSyscall = 1'b1;
                        privInst   = 1'b1;
                    end
                    fnBreak: begin
                        regWen   = 1'b0;
                        excBreak = 1'b1;
                        privInst = 1'b1;
                    end
                    default: begin
                        regWen        = 1'b0;
                        undefinedInst = 1'b1;
                    end
                endcase
            end
            opLb, opLh, opLw, opLbu, opLhu: begin
                aluOp    = aluAddu; // base + offset
                aluSelB  = 1'b1;
                regWen   = 1'b1;
                memEn    = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
            end
            opSb, opSh, opSw: begin
                aluOp    = aluAddu;
                aluSelB  = 1'b1;
                memEn    = 1'b1;
                memWrite = 1'b1;
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                regWen  = 1'b1;
                aluSelB = 1'b1; // immediate as operand b
                case (op)
                    opAddi:  aluOp = aluAdd;
                    opAddiu: aluOp = aluAddu;
                    opSlti:  aluOp = aluSlt;
                    opSltiu: aluOp = aluSltu;
                    opAndi:  aluOp = aluAnd;
                    opOri:   aluOp = aluOr;
                    opXori:  aluOp = aluXor;
                    default: aluOp = aluLui;
                endcase
            end
            opJ, opBeq, opBne, opBlez, opBgtz: aluOp = aluNop;
            opJal:  regWen = 1'b1; // ra gets pc+8
            opRegimm: begin
                // only the linking forms write ra
                regWen = (rt == rtBgezal) || (rt == rtBltzal);
            end
            opCop0: begin
                privInst = 1'b1;
                if (rs == rsMfc0) begin
                    aluOp  = aluMfc0;
                    regWen = 1'b1;
                end else if (rs == rsMtc0) begin
                    aluOp    = aluMtc0;
                    cp0Write = 1'b1;
                end
            end
            default: undefinedInst = 1'b1;
        endcase
    end

endmodule

/* hw/decodeCtrlPkg.sv */
package decodeCtrlPkg;

    typedef enum logic [7:0] {
        aluNop = 8'h00,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluAdd,
        aluAddu,
        aluSub,
        aluSubu,
        aluSll,
        aluSllv,
        aluSrl,
        aluSrlv,
        aluSra,
        aluSrav,
        aluMult,
        aluMultu,
        aluDiv,
        aluDivu,
        aluMfhi,
        aluMflo,
        aluMthi,
        aluMtlo,
        aluLui,
        aluMfc0,
        aluMtc0
    } aluOpT;

    typedef enum logic [3:0] {
        btNop = 4'h0,
        btJ,
        btJreg,    // target from rs
        btBeq,
        btBne,
        btBgtz,
        btBlez,
        btBgez,
        btBltz
    } branchT;

    // loaded in reset and on every cycle without a strobe
    localparam aluOpT  aluOpRst  = aluNop;
    localparam branchT branchRst = btNop;
    localparam logic   flagRst   = 1'b0;

endpackage

/* hw/decodeStage.sv */
`timescale 1ns/100ps

module decodeStage import mipsIsaPkg::*, decodeCtrlPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  logic [instrW-1:0] instr,
    output logic              decodedValid,
    output aluOpT             aluOp,
    output logic              aluSelA,
    output logic              aluSelB,
    output logic              regWen,
    output logic              memEn,
    output logic              memRead,
    output logic              memWrite,
    output logic              memToReg,
    output logic              hiloWrite,
    output logic              cp0Write,
    output logic              privInst,
    output logic              excSyscall,
    output logic              excBreak,
    output logic              excEret,
    output logic              undefinedInst,
    output branchT            branchType,
    output logic              linkPc8,
    output regAddrT           regWaddr,
    output logic [31:0]       extImm
);

    localparam int flagN = 15;

    aluOpT            nxtAluOp;
    branchT           nxtBranchType;
    regAddrT          nxtRegWaddr;
    logic [31:0]      nxtExtImm;
    logic             nxtAluSelA;
    logic             nxtAluSelB;
    logic             nxtRegWen;
    logic             nxtMemEn;
    logic             nxtMemRead;
    logic             nxtMemWrite;
    logic             nxtMemToReg;
    logic             nxtHiloWrite;
    logic             nxtCp0Write;
    logic             nxtPrivInst;
    logic             nxtExcSyscall;
    logic             nxtExcBreak;
    logic             nxtExcEret;
    logic             nxtUndefinedInst;
    logic             nxtLinkPc8;
    logic [flagN-1:0] nxtFlags;
    logic [flagN-1:0] flagsQ;

    ctrlDecoder ctrlDec0 (
        .instr        (instr),
        .aluOp        (nxtAluOp),
        .aluSelA      (nxtAluSelA),
        .aluSelB      (nxtAluSelB),
        .regWen       (nxtRegWen),
        .memEn        (nxtMemEn),
        .memRead      (nxtMemRead),
        .memWrite     (nxtMemWrite),
        .memToReg     (nxtMemToReg),
        .hiloWrite    (nxtHiloWrite),
        .cp0Write     (nxtCp0Write),
        .privInst     (nxtPrivInst),
        .excSyscall   (nxtExcSyscall),
        .excBreak     (nxtExcBreak),
        .excEret      (nxtExcEret),
        .undefinedInst(nxtUndefinedInst)
    );

    branchDecoder branchDec0 (
        .instr     (instr),
        .branchType(nxtBranchType),
        .linkPc8   (nxtLinkPc8)
    );

    operandDecoder operandDec0 (
        .instr   (instr),
        .regWaddr(nxtRegWaddr),
        .extImm  (nxtExtImm)
    );

    assign nxtFlags = {nxtAluSelA, nxtAluSelB, nxtRegWen, nxtMemEn, nxtMemRead,
                       nxtMemWrite, nxtMemToReg, nxtHiloWrite, nxtCp0Write, nxtPrivInst,
                       nxtExcSyscall, nxtExcBreak, nxtExcEret, nxtUndefinedInst, nxtLinkPc8};

    assign {aluSelA, aluSelB, regWen, memEn, memRead,
            memWrite, memToReg, hiloWrite, cp0Write, privInst,
            excSyscall, excBreak, excEret, undefinedInst, linkPc8} = flagsQ;

    // idle cycles clear everything so no enable lingers
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decodedValid <= 1'b0;
            aluOp        <= aluOpRst;
            branchType   <= branchRst;
            flagsQ       <= {flagN{flagRst}};
        end else if (instrValid) begin
            decodedValid <= 1'b1;
            aluOp        <= nxtAluOp;
            branchType   <= nxtBranchType;
            flagsQ       <= nxtFlags;
        end else begin
            decodedValid <= 1'b0;
            aluOp        <= aluOpRst;
            branchType   <= branchRst;
            flagsQ       <= {flagN{flagRst}};
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            regWaddr <= nxtRegWaddr; // payload only
            extImm   <= nxtExtImm;
        end
    end

    memDirExcl: assert property (@(posedge clk) disable iff (!rstN)
        !(memRead && memWrite));

    undefNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        undefinedInst |-> !(regWen || memEn));

    branchNoMem: assert property (@(posedge clk) disable iff (!rstN)
        (branchType != btNop) |-> !memEn);

endmodule

/* hw/mipsIsaPkg.sv */
package mipsIsaPkg;

    localparam int instrW   = 32;
    localparam int regAddrW = 5;

    typedef logic [regAddrW-1:0] regAddrT;

    localparam regAddrT linkReg = 5'd31; // ra

    // field lsb and width
    localparam int opLsb    = 26;
    localparam int opW      = 6;
    localparam int rsLsb    = 21;
    localparam int rsW      = 5;
    localparam int rtLsb    = 16;
    localparam int rtW      = 5;
    localparam int rdLsb    = 11;
    localparam int rdW      = 5;
    localparam int functLsb = 0;
    localparam int functW   = 6;
    localparam int immLsb   = 0;
    localparam int immW     = 16;

    localparam logic [opW-1:0] opSpecial = 6'b000000;
    localparam logic [opW-1:0] opRegimm  = 6'b000001;
    localparam logic [opW-1:0] opJ       = 6'b000010;
    localparam logic [opW-1:0] opJal     = 6'b000011;
    localparam logic [opW-1:0] opBeq     = 6'b000100;
    localparam logic [opW-1:0] opBne     = 6'b000101;
    localparam logic [opW-1:0] opBlez    = 6'b000110;
    localparam logic [opW-1:0] opBgtz    = 6'b000111;
    localparam logic [opW-1:0] opAddi    = 6'b001000;
    localparam logic [opW-1:0] opAddiu   = 6'b001001;
    localparam logic [opW-1:0] opSlti    = 6'b001010;
    localparam logic [opW-1:0] opSltiu   = 6'b001011;
    localparam logic [opW-1:0] opAndi    = 6'b001100;
    localparam logic [opW-1:0] opOri     = 6'b001101;
    localparam logic [opW-1:0] opXori    = 6'b001110;
    localparam logic [opW-1:0] opLui     = 6'b001111;
    localparam logic [opW-1:0] opCop0    = 6'b010000;
    localparam logic [opW-1:0] opLb      = 6'b100000;
    localparam logic [opW-1:0] opLh      = 6'b100001;
    localparam logic [opW-1:0] opLw      = 6'b100011;
    localparam logic [opW-1:0] opLbu     = 6'b100100;
    localparam logic [opW-1:0] opLhu     = 6'b100101;
    localparam logic [opW-1:0] opSb      = 6'b101000;
    localparam logic [opW-1:0] opSh      = 6'b101001;
    localparam logic [opW-1:0] opSw      = 6'b101011;

    // SPECIAL functs
    localparam logic [functW-1:0] fnSll     = 6'b000000;
    localparam logic [functW-1:0] fnSrl     = 6'b000010;
    localparam logic [functW-1:0] fnSra     = 6'b000011;
    localparam logic [functW-1:0] fnSllv    = 6'b000100;
    localparam logic [functW-1:0] fnSrlv    = 6'b000110;
    localparam logic [functW-1:0] fnSrav    = 6'b000111;
    localparam logic [functW-1:0] fnJr      = 6'b001000;
    localparam logic [functW-1:0] fnJalr    = 6'b001001;
    localparam logic [functW-1:0] fnSyscall = 6'b001100;
    localparam logic [functW-1:0] fnBreak   = 6'b001101;
    localparam logic [functW-1:0] fnMfhi    = 6'b010000;
    localparam logic [functW-1:0] fnMthi    = 6'b010001;
    localparam logic [functW-1:0] fnMflo    = 6'b010010;
    localparam logic [functW-1:0] fnMtlo    = 6'b010011;
    localparam logic [functW-1:0] fnMult    = 6'b011000;
    localparam logic [functW-1:0] fnMultu   = 6'b011001;
    localparam logic [functW-1:0] fnDiv     = 6'b011010;
    localparam logic [functW-1:0] fnDivu    = 6'b011011;
    localparam logic [functW-1:0] fnAdd     = 6'b100000;
    localparam logic [functW-1:0] fnAddu    = 6'b100001;
    localparam logic [functW-1:0] fnSub     = 6'b100010;
    localparam logic [functW-1:0] fnSubu    = 6'b100011;
    localparam logic [functW-1:0] fnAnd     = 6'b100100;
    localparam logic [functW-1:0] fnOr      = 6'b100101;
    localparam logic [functW-1:0] fnXor     = 6'b100110;
    localparam logic [functW-1:0] fnNor     = 6'b100111;
    localparam logic [functW-1:0] fnSlt     = 6'b101010;
    localparam logic [functW-1:0] fnSltu    = 6'b101011;

    // REGIMM rt codes
    localparam logic [rtW-1:0] rtBltz   = 5'b00000;
    localparam logic [rtW-1:0] rtBgez   = 5'b00001;
    localparam logic [rtW-1:0] rtBltzal = 5'b10000;
    localparam logic [rtW-1:0] rtBgezal = 5'b10001;

    localparam logic [rsW-1:0] rsMfc0 = 5'b00000;
    localparam logic [rsW-1:0] rsMtc0 = 5'b00100;

    localparam logic [instrW-1:0] eretWord = 32'h4200_0018;

endpackage

/* hw/operandDecoder.sv */
`timescale 1ns/100ps

module operandDecoder import mipsIsaPkg::*; (
    input  logic [instrW-1:0] instr,
    output regAddrT           regWaddr,
    output logic [31:0]       extImm
);

    logic [opW-1:0]  op;
    logic [rsW-1:0]  rs;
    logic [rtW-1:0]  rt;
    logic [rdW-1:0]  rd;
    logic [immW-1:0] imm;
    logic            zeroExt;

    assign op  = instr[opLsb +: opW];
    assign rs  = instr[rsLsb +: rsW];
    assign rt  = instr[rtLsb +: rtW];
    assign rd  = instr[rdLsb +: rdW];
    assign imm = instr[immLsb +: immW];

    // andi ori xori lui, instr[29:28] both set
    assign zeroExt = (op[3:2] == 2'b11);

    assign extImm = zeroExt ? {{(32-immW){1'b0}}, imm}
                            : {{(32-immW){imm[immW-1]}}, imm};

    always_comb begin
        regWaddr = rd;
        case (op)
            opAddi, opAddiu, opSlti, opSltiu,
            opAndi, opOri, opXori, opLui,
            opLb, opLh, opLw, opLbu, opLhu: regWaddr = rt;
            opJal: regWaddr = linkReg;
            opRegimm: begin
                if (rt == rtBgezal || rt == rtBltzal) begin
                    regWaddr = linkReg;
                end
            end
            opCop0: begin
                if (rs == rsMfc0) begin
                    regWaddr = rt; // gpr[rt] from cp0[rd]
                end
            end
            default: regWaddr = rd;
        endcase
    end

endmodule
